//--- src/alu_pkg.sv
// alu shared definitions: widths, data types, operation codes and shift kinds
`default_nettype none

package alu_pkg;

  //----------------------------------------------------------------------
  // widths
  //----------------------------------------------------------------------
  localparam int DATA_WIDTH  = 32;  // operand and result width
  localparam int SHAMT_WIDTH = 5;   // shift amount, low bits of op2
  localparam int OP_WIDTH    = 4;   // {funct7 bit, funct3}

  //----------------------------------------------------------------------
  // data types
  //----------------------------------------------------------------------
  typedef logic [DATA_WIDTH-1:0]  data_t;   // operands, partial results, result
  typedef logic [SHAMT_WIDTH-1:0] shamt_t;  // shift amount

  // operation code, msb is the funct7 alternate bit, low bits are funct3
  typedef enum logic [OP_WIDTH-1:0] {
    ADD_OP  = 4'b0000,
    SLL_OP  = 4'b0001,
    PASS_OP = 4'b0011,  // result = op2
    XOR_OP  = 4'b0100,
    SRL_OP  = 4'b0101,
    OR_OP   = 4'b0110,
    AND_OP  = 4'b0111,
    SUB_OP  = 4'b1000,
    SRA_OP  = 4'b1101
  } alu_op_e;

  // decoded shift request, none must stay at zero for the reset value
  typedef enum logic [1:0] {
    SHIFT_NONE        = 2'd0,
    SHIFT_LEFT        = 2'd1,
    SHIFT_RIGHT_LOGIC = 2'd2,
    SHIFT_RIGHT_ARITH = 2'd3
  } shift_kind_e;

  // mirror a data word, bit 0 <-> bit DATA_WIDTH-1
  function automatic data_t reverse_bits(input data_t value);
    data_t rev;
    for (int i = 0; i < DATA_WIDTH; i++) begin
      rev[i] = value[DATA_WIDTH-1-i];
    end
    return rev;
  endfunction

endpackage

`default_nettype wire

//--- src/alu_issue_if.sv
// alu issue bundle carrying a registered, decoded operation into the execute stage
`timescale 1ns/1ps
`default_nettype none

interface alu_issue_if;
  import alu_pkg::*;

  data_t       op1;         // first operand
  data_t       op2;         // second operand
  data_t       shift_src;   // op1, bit-reversed for a left shift
  shamt_t      shamt;       // low bits of op2
  shift_kind_e shift_kind;  // decoded once in the operand stage
  alu_op_e     aluop;       // raw code for the arith/logic unit

  // operand stage side
  modport src (
    output op1, op2, shift_src, shamt, shift_kind, aluop
  );

  // execute stage side
  modport dst (
    input op1, op2, shift_src, shamt, shift_kind, aluop
  );

endinterface

`default_nettype wire

//--- src/alu_barrel_shifter.sv
// alu barrel shifter: one shared arithmetic right shifter serving sll, srl and sra
`timescale 1ns/1ps
`default_nettype none

module alu_barrel_shifter (
  input  alu_pkg::data_t       i_shift_src,
  input  alu_pkg::shamt_t      i_shamt,
  input  alu_pkg::shift_kind_e i_shift_kind,
  output alu_pkg::data_t       o_shift_result
);
  import alu_pkg::*;

  logic              fill;     // bit shifted in from the top
  logic [DATA_WIDTH:0] shifted;  // source plus fill bit after the shift
  data_t             trimmed;  // fill bit dropped

  // sign fill only for sra, zero for srl and the mirrored sll
  assign fill = (i_shift_kind == SHIFT_RIGHT_ARITH) & i_shift_src[DATA_WIDTH-1];

  // extra top bit makes >>> act as logical when fill is 0
  assign shifted = $signed({fill, i_shift_src}) >>> i_shamt;
  assign trimmed = shifted[DATA_WIDTH-1:0];

  always_comb begin
    case (i_shift_kind)
      SHIFT_LEFT:        o_shift_result = reverse_bits(trimmed);  // mirror back
      SHIFT_RIGHT_LOGIC: o_shift_result = trimmed;
      SHIFT_RIGHT_ARITH: o_shift_result = trimmed;
      default:           o_shift_result = '0;  // no shift, keeps the or-merge clean
    endcase
  end

endmodule

`default_nettype wire

//--- src/alu_arith_logic.sv
// alu arithmetic and logic unit: add, sub, xor, or, and, pass op2
`timescale 1ns/1ps
`default_nettype none

module alu_arith_logic (
  input  alu_pkg::data_t   i_op1,
  input  alu_pkg::data_t   i_op2,
  input  alu_pkg::alu_op_e i_aluop,
  output alu_pkg::data_t   o_arith_result
);
  import alu_pkg::*;

  data_t sum;   // op1 + op2, wraps at full width
  data_t diff;  // op1 - op2, wraps at full width

  assign sum  = i_op1 + i_op2;
  assign diff = i_op1 - i_op2;

  //----------------------------------------------------------------------
  // result select
  //----------------------------------------------------------------------
  always_comb begin
    case (i_aluop)
      ADD_OP:  o_arith_result = sum;
      SUB_OP:  o_arith_result = diff;
      XOR_OP:  o_arith_result = i_op1 ^ i_op2;
      OR_OP:   o_arith_result = i_op1 | i_op2;
      AND_OP:  o_arith_result = i_op1 & i_op2;
      PASS_OP: o_arith_result = i_op2;  // pass second operand
      // shifts and undefined codes read zero here
      default: o_arith_result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/alu_operand_stage.sv
// alu operand stage: registers operands and op, decodes shift kind, preps shift source
`timescale 1ns/1ps
`default_nettype none

module alu_operand_stage (
  input  logic             clk,
  input  logic             i_reset,
  input  alu_pkg::data_t   i_op1,
  input  alu_pkg::data_t   i_op2,
  input  alu_pkg::alu_op_e i_aluop,
  alu_issue_if.src         o_issue
);
  import alu_pkg::*;

  shift_kind_e shift_kind_d;  // decoded shift request
  data_t       shift_src_d;   // source fed to the shared right shifter

  //----------------------------------------------------------------------
  // decode
  //----------------------------------------------------------------------
  always_comb begin
    case (i_aluop)
      SLL_OP:  shift_kind_d = SHIFT_LEFT;
      SRL_OP:  shift_kind_d = SHIFT_RIGHT_LOGIC;
      SRA_OP:  shift_kind_d = SHIFT_RIGHT_ARITH;
      default: shift_kind_d = SHIFT_NONE;      // not a shift
    endcase
  end

  // left shift runs as a right shift on the mirrored word
  assign shift_src_d = (i_aluop == SLL_OP) ? reverse_bits(i_op1) : i_op1;

  //----------------------------------------------------------------------
  // stage 1 registers
  //----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_issue.op1        <= '0;
      o_issue.op2        <= '0;
      o_issue.shift_src  <= '0;
      o_issue.shamt      <= '0;
      o_issue.shift_kind <= SHIFT_NONE;
      o_issue.aluop      <= ADD_OP;              // cleared stage is add 0 + 0
    end else begin
      o_issue.op1        <= i_op1;
      o_issue.op2        <= i_op2;
      o_issue.shift_src  <= shift_src_d;
      o_issue.shamt      <= i_op2[SHAMT_WIDTH-1:0];  // upper op2 bits ignored
      o_issue.shift_kind <= shift_kind_d;
      o_issue.aluop      <= i_aluop;
    end
  end

endmodule

`default_nettype wire

//--- src/alu_execute_stage.sv
// alu execute stage: runs shifter and arith/logic unit, merges and registers the result
`timescale 1ns/1ps
`default_nettype none

module alu_execute_stage (
  input  logic           clk,
  input  logic           i_reset,
  alu_issue_if.dst       i_issue,
  output alu_pkg::data_t o_result
);
  import alu_pkg::*;

  data_t shift_result;  // zero unless a shift is issued
  data_t arith_result;  // zero for shifts and undefined codes
  data_t merged;        // both partials or'ed together

  //----------------------------------------------------------------------
  // combinational units
  //----------------------------------------------------------------------
  alu_barrel_shifter u_shifter (
    .i_shift_src    (i_issue.shift_src),
    .i_shamt        (i_issue.shamt),
    .i_shift_kind   (i_issue.shift_kind),
    .o_shift_result (shift_result)
  );

  alu_arith_logic u_arith_logic (
    .i_op1          (i_issue.op1),
    .i_op2          (i_issue.op2),
    .i_aluop        (i_issue.aluop),
    .o_arith_result (arith_result)
  );

  // at most one unit is non-zero per op
  assign merged = shift_result | arith_result;

  //----------------------------------------------------------------------
  // stage 2 result register
  //----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_result <= '0;
    end else begin
      o_result <= merged;
    end
  end

endmodule

`default_nettype wire

//--- src/alu_top.sv
// alu top: two-stage pipelined integer alu, result two cycles after the inputs
`timescale 1ns/1ps
`default_nettype none

module alu_top (
  input  logic             clk,
  input  logic             i_reset,
  input  alu_pkg::data_t   i_op1,
  input  alu_pkg::data_t   i_op2,
  input  alu_pkg::alu_op_e i_aluop,
  output alu_pkg::data_t   o_result
);

  // stage 1 -> stage 2 bundle
  alu_issue_if issue ();

  // operands, op code and shift prep, registered
  alu_operand_stage u_operand_stage (
    .clk     (clk),
    .i_reset (i_reset),
    .i_op1   (i_op1),
    .i_op2   (i_op2),
    .i_aluop (i_aluop),
    .o_issue (issue)
  );

  // units plus result register
  alu_execute_stage u_execute_stage (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_issue  (issue),
    .o_result (o_result)
  );

endmodule

`default_nettype wire

//--- verification/alu_assertions.sv
// alu execute stage assertions: reset clear, zero for undefined codes, shift decode
`timescale 1ns/1ps
`default_nettype none

module alu_assertions (
  input logic                 clk,
  input logic                 i_reset,
  input alu_pkg::shift_kind_e i_shift_kind,
  input alu_pkg::alu_op_e     i_aluop,
  input alu_pkg::data_t       i_result
);
  import alu_pkg::*;

  int unsigned reset_fails  = 0;  // failure counts, summed by the testbench
  int unsigned undef_fails  = 0;
  int unsigned decode_fails = 0;
  logic        undefined_op;

  assign undefined_op = !(i_aluop inside {ADD_OP, SLL_OP, PASS_OP, XOR_OP, SRL_OP,
                                          OR_OP, AND_OP, SUB_OP, SRA_OP});

  a_reset_clears: assert property (@(posedge clk) i_reset |=> (i_result == '0))
    else begin
      reset_fails++;
      $error("result register not cleared on the cycle after reset");
    end

  a_undef_zero: assert property (@(posedge clk) disable iff (i_reset)
      (i_shift_kind == SHIFT_NONE && undefined_op) |=> (i_result == '0))
    else begin
      undef_fails++;
      $error("undefined operation code gave a non-zero result");
    end

  a_shift_decoded: assert property (@(posedge clk)
      (i_aluop inside {SLL_OP, SRL_OP, SRA_OP}) |-> (i_shift_kind != SHIFT_NONE))
    else begin
      decode_fails++;
      $error("shift operation issued without a shift kind");
    end

endmodule

bind alu_execute_stage alu_assertions u_assertions (
  .clk          (clk),
  .i_reset      (i_reset),
  .i_shift_kind (i_issue.shift_kind),
  .i_aluop      (i_issue.aluop),
  .i_result     (o_result)
);

`default_nettype wire

//--- verification/alu_checker.sv
// alu checker: reference model on the DUT inputs, compares o_result at the ports
`timescale 1ns/1ps
`default_nettype none

module alu_checker (
  input  logic             clk,
  input  logic             i_reset,
  input  alu_pkg::data_t   i_op1,
  input  alu_pkg::data_t   i_op2,
  input  alu_pkg::alu_op_e i_aluop,
  input  alu_pkg::data_t   i_result,
  output int unsigned      o_check_count,
  output int unsigned      o_error_count
);
  import alu_pkg::*;

  localparam int PIPE_LATENCY = 2;  // results in flight

  data_t       expect_q[$];  // expected results, oldest first
  string       desc_q[$];    // matching op description for error lines
  int unsigned checks = 0;
  int unsigned errors = 0;

  assign o_check_count = checks;
  assign o_error_count = errors;

  // expected result straight from the operation rules
  function automatic data_t model(input alu_op_e op, input data_t a, input data_t b);
    shamt_t sh;
    sh = b[SHAMT_WIDTH-1:0];  // only the low five bits shift
    case (op)
      ADD_OP:  return a + b;
      SUB_OP:  return a - b;
      XOR_OP:  return a ^ b;
      OR_OP:   return a | b;
      AND_OP:  return a & b;
      PASS_OP: return b;
      SLL_OP:  return a << sh;
      SRL_OP:  return a >> sh;
      SRA_OP:  return data_t'($signed(a) >>> sh);
      default: return '0;     // undefined codes
    endcase
  endfunction

  //----------------------------------------------------------------------
  // inputs are stable at the falling edge and are taken at the next rise
  //----------------------------------------------------------------------
  always @(negedge clk) begin
    if (expect_q.size() == PIPE_LATENCY) begin
      checks++;
      if (i_result !== expect_q[0]) begin
        errors++;
        $display("mismatch o_result: expected 0x%08h got 0x%08h (%s)",
                 expect_q[0], i_result, desc_q[0]);
      end
      expect_q.delete(0);
      desc_q.delete(0);
    end
    if (i_reset) begin
      // result register and operand stage (add 0 + 0) both read zero
      expect_q.delete();
      desc_q.delete();
      expect_q.push_back('0);
      expect_q.push_back('0);
      desc_q.push_back("reset");
      desc_q.push_back("first cycle after reset");
    end else begin
      expect_q.push_back(model(i_aluop, i_op1, i_op2));
      desc_q.push_back($sformatf("op 0x%01h op1 0x%08h op2 0x%08h", i_aluop, i_op1, i_op2));
    end
  end

endmodule

`default_nettype wire

//--- verification/alu_tb.sv
// alu testbench: clock, reset, seeded random operations, per-test lines and closing counts
`timescale 1ns/1ps
`default_nettype none

module alu_tb;
  import alu_pkg::*;

  localparam int PIPE_LATENCY  = 2;   // input edge to result register
  localparam int DRAIN_TIMEOUT = 20;  // cycles allowed for the last checks of a test

  logic        clk;
  logic        i_reset;
  data_t       i_op1;
  data_t       i_op2;
  alu_op_e     i_aluop;
  data_t       o_result;
  int unsigned check_count;
  int unsigned error_count;
  int unsigned checks_at_start = 0;
  int unsigned errors_at_start = 0;
  int unsigned ops_issued      = 0;   // ops driven in the current test
  int unsigned tests_run       = 0;
  int unsigned tests_failed    = 0;
  int unsigned assert_fails;

  alu_op_e              shift_ops[3]   = '{SLL_OP, SRL_OP, SRA_OP};
  logic [OP_WIDTH-1:0]  undef_codes[7] = '{4'h2, 4'h9, 4'hA, 4'hB, 4'hC, 4'hE, 4'hF};

  alu_top UUT (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_op1    (i_op1),
    .i_op2    (i_op2),
    .i_aluop  (i_aluop),
    .o_result (o_result)
  );

  alu_checker u_checker (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_op1         (i_op1),
    .i_op2         (i_op2),
    .i_aluop       (i_aluop),
    .i_result      (o_result),
    .o_check_count (check_count),
    .o_error_count (error_count)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  //----------------------------------------------------------------------
  // stimulus helpers
  //----------------------------------------------------------------------
  function automatic data_t corner_word();
    case ($urandom_range(0, 7))
      0:       return 32'hffff_ffff;
      1:       return 32'h7fff_ffff;  // largest positive, add overflows
      2:       return 32'h8000_0000;
      3:       return 32'h0000_0000;
      default: return $urandom();
    endcase
  endfunction

  task automatic drive_op(input alu_op_e op, input data_t a, input data_t b);
    @(posedge clk);
    #1;                   // inputs change 1 ns after the edge
    i_aluop = op;
    i_op1   = a;
    i_op2   = b;
    ops_issued++;
  endtask

  task automatic finish_test(input string name);
    int unsigned waited;
    int unsigned errors;
    int unsigned needed;
    logic        timed_out;
    // idle edge before the first drive, then the pipeline latency
    needed = ops_issued + PIPE_LATENCY + 1;
    waited = 0;
    while ((check_count - checks_at_start < needed) && (waited < DRAIN_TIMEOUT)) begin
      @(posedge clk);
      waited++;
    end
    timed_out = (check_count - checks_at_start < needed);
    if (timed_out) $display("test %s timed out waiting for its result checks", name);
    errors = error_count - errors_at_start;
    tests_run++;
    if (timed_out || errors != 0) tests_failed++;
    $display("test %-6s ops %0d checks %0d mismatches %0d %s", name, ops_issued,
             check_count - checks_at_start, errors,
             (timed_out || errors != 0) ? "failed" : "passed");
    checks_at_start = check_count;
    errors_at_start = error_count;
    ops_issued      = 0;
  endtask

  //----------------------------------------------------------------------
  // test sequence
  //----------------------------------------------------------------------
  initial begin
    logic [31:0] r;
    alu_op_e     op;
    void'($urandom(32));  // fixed seed, once
    i_reset = 1'b1;
    i_op1   = $urandom();  // non-zero inputs, reset must hide them
    i_op2   = $urandom();
    i_aluop = XOR_OP;
    repeat (5) @(posedge clk);
    #1 i_reset = 1'b0;
    ops_issued = 5;       // reset cycles count as issued slots
    finish_test("reset");

    for (int i = 0; i < 200; i++) begin
      op = ($urandom_range(0, 1) == 0) ? ADD_OP : SUB_OP;
      drive_op(op, corner_word(), corner_word());
    end
    finish_test("arith");

    for (int i = 0; i < 200; i++) begin
      r  = $urandom_range(0, 2);
      op = (r == 0) ? XOR_OP : (r == 1) ? OR_OP : AND_OP;
      drive_op(op, $urandom(), $urandom());
    end
    finish_test("logic");

    foreach (shift_ops[i]) begin
      drive_op(shift_ops[i], $urandom() | 32'h8000_0000, 32'hffff_ffe0);  // amount 0
      drive_op(shift_ops[i], $urandom() | 32'h8000_0000, 32'hffff_ffff);  // amount 31
      drive_op(shift_ops[i], $urandom(), $urandom() | 32'hf000_0000);     // high op2 bits
    end
    for (int i = 0; i < 150; i++) begin
      drive_op(shift_ops[$urandom_range(0, 2)], corner_word(), $urandom());
    end
    finish_test("shift");

    for (int i = 0; i < 20; i++) drive_op(PASS_OP, $urandom(), corner_word());
    foreach (undef_codes[i]) begin
      for (int j = 0; j < 5; j++) drive_op(alu_op_e'(undef_codes[i]), $urandom(), $urandom());
    end
    finish_test("pass");

    for (int i = 0; i < 1000; i++) begin
      r = $urandom();
      drive_op(alu_op_e'(r[OP_WIDTH-1:0]), corner_word(), corner_word());  // all 16 codes
    end
    finish_test("stream");

    assert_fails = UUT.u_execute_stage.u_assertions.reset_fails +
                   UUT.u_execute_stage.u_assertions.undef_fails +
                   UUT.u_execute_stage.u_assertions.decode_fails;
    $display("tests %0d, failed %0d, checks %0d, mismatches %0d, assertion failures %0d",
             tests_run, tests_failed, check_count, error_count, assert_fails);
    if (tests_failed == 0 && error_count == 0 && assert_fails == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- pipelined_alu.f
src/alu_pkg.sv
src/alu_issue_if.sv
src/alu_barrel_shifter.sv
src/alu_arith_logic.sv
src/alu_operand_stage.sv
src/alu_execute_stage.sv
src/alu_top.sv
verification/alu_assertions.sv
verification/alu_checker.sv
verification/alu_tb.sv

//--- Makefile
# Verilator build and run for the pipelined ALU testbench
VERILATOR ?= verilator
TOP       ?= alu_tb
FILELIST  ?= pipelined_alu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Test OK" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
